// ==== design/audio_pkg.sv ====
// audio package
// widths, register map, voice configuration and the CB2 level for the audio block

package audio_pkg;

    typedef logic        [4:0]  reg_addr_t;  // sound chip register address
    typedef logic        [7:0]  reg_data_t;  // cpu data byte
    typedef logic        [15:0] phase_t;     // voice phase and freq step
    typedef logic signed [11:0] sample_t;    // voice output sample
    typedef logic signed [15:0] mix_t;       // mixed audio, also dac input
    typedef logic        [3:0]  volume_t;    // master volume

    typedef struct packed {
        phase_t freq;         // phase step per cpu enable
        logic   gate;         // voice on, phase held at 0 when low
        logic   wave_square;  // square waveform select
        logic   wave_saw;     // sawtooth waveform select
    } voice_cfg_t;

    localparam int NUM_VOICES = 3;

    // register map, voice registers repeat every stride
    localparam reg_addr_t VOICE_STRIDE = 5'd7;
    localparam reg_addr_t REG_FREQ_LO  = 5'd0;   // offset inside voice
    localparam reg_addr_t REG_FREQ_HI  = 5'd1;   // offset inside voice
    localparam reg_addr_t REG_CTRL     = 5'd4;   // offset inside voice
    localparam reg_addr_t REG_VOLUME   = 5'h18;  // volume in low nibble
    localparam reg_addr_t REG_OSC3     = 5'h1B;  // read only

    localparam mix_t CB2_LEVEL = 16'sh0800;  // added or removed by the via cb2 line

endpackage

// ==== design/tone_regs.sv ====
// sound chip register file
// cpu writes on the 1 MHz enable, osc3 read-back, per-voice config and volume out

module tone_regs (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   cpu_en_i,
    input  logic                   sid_en_i,
    input  logic                   cpu_wr_en_i,
    input  audio_pkg::reg_addr_t   addr_i,
    input  audio_pkg::reg_data_t   data_i,
    input  audio_pkg::phase_t      osc3_phase_i,   // voice 2 phase
    output audio_pkg::reg_data_t   data_o,
    output audio_pkg::voice_cfg_t  voice_cfg_o [audio_pkg::NUM_VOICES],
    output audio_pkg::volume_t     volume_o
);
    import audio_pkg::*;

    voice_cfg_t cfg_q [NUM_VOICES];  // one config per voice
    volume_t    volume_q;
    logic       wr_stb;              // qualified cpu write
    logic [1:0] voice_idx;           // decoded voice number
    reg_addr_t  reg_off;             // offset inside voice block
    logic       voice_hit;           // address falls in a voice block

    assign wr_stb = cpu_en_i && sid_en_i && cpu_wr_en_i;

    // split address into voice index and offset
    always_comb begin
        voice_idx = '0;
        reg_off   = addr_i;
        voice_hit = 1'b0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (addr_i >= reg_addr_t'(v * VOICE_STRIDE) &&
                addr_i <  reg_addr_t'((v + 1) * VOICE_STRIDE)) begin
                voice_idx = 2'(v);
                reg_off   = addr_i - reg_addr_t'(v * VOICE_STRIDE);
                voice_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                cfg_q[v] <= '0;
            end
            volume_q <= '0;
        end else if (wr_stb) begin
            if (voice_hit) begin
                case (reg_off)
                    REG_FREQ_LO: cfg_q[voice_idx].freq[7:0]  <= data_i;
                    REG_FREQ_HI: cfg_q[voice_idx].freq[15:8] <= data_i;
                    REG_CTRL: begin
                        cfg_q[voice_idx].gate        <= data_i[0];  // bit 0
                        cfg_q[voice_idx].wave_square <= data_i[4];  // bit 4
                        cfg_q[voice_idx].wave_saw    <= data_i[5];  // bit 5
                    end
                    default: ;  // unused voice regs ignored
                endcase
            end else if (addr_i == REG_VOLUME) begin
                volume_q <= data_i[3:0];  // low nibble only
            end
        end
    end

    assign voice_cfg_o = cfg_q;
    assign volume_o    = volume_q;

    // write-only regs read 0, osc3 gives top of voice 2 phase
    assign data_o = (addr_i == REG_OSC3) ? osc3_phase_i[15:8] : '0;

endmodule

// ==== design/tone_voice.sv ====
// tone voice
// phase accumulator stepped on the cpu enable, shaped into square or sawtooth

module tone_voice (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  cpu_en_i,
    input  audio_pkg::voice_cfg_t cfg_i,
    output audio_pkg::phase_t     phase_o,
    output audio_pkg::sample_t    sample_o
);
    import audio_pkg::*;

    localparam sample_t SAMPLE_MAX = 12'sh7FF;
    localparam sample_t SAMPLE_MIN = 12'sh800;

    phase_t  phase_q;
    sample_t saw_wave;     // sawtooth from top phase bits
    sample_t square_wave;  // full scale square

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            phase_q <= '0;
        end else if (!cfg_i.gate) begin
            phase_q <= '0;  // gate off holds phase
        end else if (cpu_en_i) begin
            phase_q <= phase_q + cfg_i.freq;  // wraps mod 2^16
        end
    end

    // unsigned ramp to signed by flipping msb
    assign saw_wave    = {~phase_q[15], phase_q[14:4]};
    assign square_wave = phase_q[15] ? SAMPLE_MAX : SAMPLE_MIN;

    always_comb begin
        sample_o = '0;  // silent unless gated and a wave picked
        if (cfg_i.gate) begin
            case ({cfg_i.wave_square, cfg_i.wave_saw})
                2'b01:   sample_o = saw_wave;
                2'b10:   sample_o = square_wave;
                2'b11:   sample_o = saw_wave & square_wave;  // combined waveform
                default: sample_o = '0;
            endcase
        end
    end

    assign phase_o = phase_q;

endmodule

// ==== design/audio_mixer.sv ====
// audio mixer
// sums the voices, applies master volume and cb2 level, clamps to 16 bits

module audio_mixer (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 via_cb2_i,
    input  logic                 diag_i,
    input  audio_pkg::sample_t   samples_i [audio_pkg::NUM_VOICES],
    input  audio_pkg::volume_t   volume_i,
    output audio_pkg::mix_t      mix_o
);
    import audio_pkg::*;

    logic signed [19:0] voice_sum;  // room for 3 x 12 bit x 15
    logic signed [19:0] vol_ext;    // volume as positive signed
    logic signed [19:0] scaled;
    logic signed [19:0] with_cb2;
    mix_t               mix_next;
    mix_t               mix_q;

    always_comb begin
        voice_sum = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            voice_sum = voice_sum + 20'(samples_i[v]);  // sign extended
        end
    end

    assign vol_ext = $signed({16'd0, volume_i});
    assign scaled  = (voice_sum * vol_ext) >>> 2;

    // cb2 pushes level up when jumper allows, down otherwise
    assign with_cb2 = (via_cb2_i && diag_i) ? scaled + 20'(CB2_LEVEL)
                                            : scaled - 20'(CB2_LEVEL);

    always_comb begin
        if (with_cb2 > 20'sd32767) begin
            mix_next = 16'sh7FFF;  // clip high
        end else if (with_cb2 < -20'sd32768) begin
            mix_next = 16'sh8000;  // clip low
        end else begin
            mix_next = with_cb2[15:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mix_q <= '0;
        end else begin
            mix_q <= mix_next;
        end
    end

    assign mix_o = mix_q;

endmodule

// ==== design/delta_sigma_dac.sv ====
// first-order delta-sigma dac
// signed mix to 1-bit pulse density from the accumulator carry

module delta_sigma_dac (
    input  logic            clk_i,
    input  logic            reset_i,
    input  audio_pkg::mix_t dac_i,
    output logic            dac_o
);
    import audio_pkg::*;

    logic [15:0] biased;  // offset binary, 0x8000 is midscale
    logic [16:0] acc_q;   // msb is the carry out

    assign biased = dac_i + 16'h8000;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            acc_q <= '0;
        end else begin
            acc_q <= acc_q[15:0] + biased;  // carry dropped into next sum
        end
    end

    assign dac_o = acc_q[16];

endmodule

// ==== design/audio.sv ====
// audio top level
// register file, three tone voices, mixer with cb2 and delta-sigma dac

module audio (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 cpu_en_i,      // 1 MHz enable
    input  logic                 sid_en_i,      // chip select
    input  logic                 cpu_wr_en_i,
    input  audio_pkg::reg_addr_t addr_i,
    input  audio_pkg::reg_data_t data_i,        // cpu write data
    output audio_pkg::reg_data_t data_o,        // cpu read data
    input  logic                 diag_i,        // diagnostic jumper
    input  logic                 via_cb2_i,
    output logic                 audio_o        // pdm audio pin
);
    import audio_pkg::*;

    voice_cfg_t voice_cfg    [NUM_VOICES];
    phase_t     voice_phase  [NUM_VOICES];
    sample_t    voice_sample [NUM_VOICES];
    volume_t    volume;
    mix_t       mix;

    tone_regs regs (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cpu_en_i     (cpu_en_i),
        .sid_en_i     (sid_en_i),
        .cpu_wr_en_i  (cpu_wr_en_i),
        .addr_i       (addr_i),
        .data_i       (data_i),
        .osc3_phase_i (voice_phase[NUM_VOICES-1]),  // voice 2 feeds osc3
        .data_o       (data_o),
        .voice_cfg_o  (voice_cfg),
        .volume_o     (volume)
    );

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        tone_voice voice (
            .clk_i    (clk_i),
            .reset_i  (reset_i),
            .cpu_en_i (cpu_en_i),
            .cfg_i    (voice_cfg[v]),
            .phase_o  (voice_phase[v]),
            .sample_o (voice_sample[v])
        );
    end

    audio_mixer mixer (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .via_cb2_i (via_cb2_i),
        .diag_i    (diag_i),
        .samples_i (voice_sample),
        .volume_i  (volume),
        .mix_o     (mix)
    );

    delta_sigma_dac dac (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .dac_i   (mix),
        .dac_o   (audio_o)
    );

endmodule

// ==== test/audio_checker.sv ====
// audio checker
// models register writes, voice phases and mix from the register map rules,
// compares cpu read data and the dac pulse density over each reset window

module audio_checker (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 cpu_en_i,
    input  logic                 sid_en_i,
    input  logic                 cpu_wr_en_i,
    input  audio_pkg::reg_addr_t addr_i,
    input  audio_pkg::reg_data_t data_i,
    input  audio_pkg::reg_data_t rd_data_i,  // dut data_o
    input  logic                 diag_i,
    input  logic                 via_cb2_i,
    input  logic                 audio_i,    // dut audio_o
    output int                   value_errs_o,
    output int                   other_errs_o,
    output int                   windows_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import audio_pkg::*;

    voice_cfg_t  cfg_m   [NUM_VOICES];  // expected voice config
    int unsigned steps_m [NUM_VOICES];  // cpu enables since gate went high
    volume_t     volume_m   = '0;
    int          mix_m      = 0;        // expected registered mix
    longint      bias_sum   = 0;        // biased mix words fed to dac since reset
    int          high_cnt   = 0;        // audio_o high cycles in window
    logic        window_on  = 1'b0;
    int          value_errs = 0;
    int          other_errs = 0;
    int          windows    = 0;

    assign value_errs_o = value_errs;
    assign other_errs_o = other_errs;
    assign windows_o    = windows;

    // phase after k steps of freq wrapping at 16 bits
    function automatic phase_t phase_after(int unsigned k, phase_t freq);
        return phase_t'(k * freq);
    endfunction

    function automatic int wave_sample(voice_cfg_t cfg, phase_t ph);
        int saw;
        int sq;
        saw = int'(ph[15:4]) - 2048;         // offset binary ramp to signed
        sq  = ph[15] ? 2047 : -2048;         // full scale square
        if (!cfg.gate)
            return 0;
        if (cfg.wave_square && cfg.wave_saw)
            return saw & sq;
        if (cfg.wave_square)
            return sq;
        if (cfg.wave_saw)
            return saw;
        return 0;
    endfunction

    function automatic int scaled_mix(int sum, volume_t vol, logic cb2, logic diag);
        int m;
        m = (sum * int'(vol)) >>> 2;
        m = (cb2 && diag) ? m + int'(CB2_LEVEL) : m - int'(CB2_LEVEL);
        if (m > 32767)
            m = 32767;
        else if (m < -32768)
            m = -32768;
        return m;
    endfunction

    // carries out of a 16 bit accumulator started at 0
    function automatic int carry_count(longint sum);
        return int'(sum / 65536);
    endfunction

    task automatic apply_write(reg_addr_t a, reg_data_t d);
        int        v;
        reg_addr_t off;
        v   = int'(a / VOICE_STRIDE);
        off = a % VOICE_STRIDE;
        if (v < NUM_VOICES) begin
            case (off)
                REG_FREQ_LO: cfg_m[v].freq[7:0]  = d;
                REG_FREQ_HI: cfg_m[v].freq[15:8] = d;
                REG_CTRL: begin
                    cfg_m[v].gate        = d[0];
                    cfg_m[v].wave_square = d[4];
                    cfg_m[v].wave_saw    = d[5];
                end
                default: ;
            endcase
        end else if (a == REG_VOLUME) begin
            volume_m = d[3:0];
        end
    endtask

    always @(posedge clk_i) begin : compare
        int        sum;
        phase_t    osc3;
        reg_data_t exp_rd;
        if (window_on && $isunknown(audio_i)) begin
            other_errs++;
            $display("audio_o is unknown at %0d ns", $time);
        end else if (window_on) begin
            high_cnt += int'(audio_i);  // carry from the previous edge
        end
        if (reset_i) begin
            if (window_on) begin
                windows++;
                if (high_cnt != carry_count(bias_sum)) begin
                    value_errs++;
                    $display("error at %0d ns: audio_o high count expected %0d got %0d",
                             $time, carry_count(bias_sum), high_cnt);
                end
            end
            window_on = 1'b0;
            high_cnt  = 0;
            bias_sum  = 0;
            mix_m     = 0;
            volume_m  = '0;
            for (int v = 0; v < NUM_VOICES; v++) begin
                cfg_m[v]   = '0;
                steps_m[v] = 0;
            end
        end else begin
            window_on = 1'b1;
            if (cpu_en_i && sid_en_i && !cpu_wr_en_i) begin
                osc3   = phase_after(steps_m[2], cfg_m[2].freq);
                exp_rd = (addr_i == REG_OSC3) ? osc3[15:8] : '0;
                if ($isunknown(rd_data_i)) begin
                    other_errs++;
                    $display("read data is unknown at %0d ns, address %02h", $time, addr_i);
                end else if (rd_data_i != exp_rd) begin
                    value_errs++;
                    $display("error at %0d ns: data_o expected %02h got %02h (addr %02h)",
                             $time, exp_rd, rd_data_i, addr_i);
                end
            end
            bias_sum += longint'(mix_m + 32768);  // dac adds last registered mix
            sum = 0;
            for (int v = 0; v < NUM_VOICES; v++) begin
                sum += wave_sample(cfg_m[v], phase_after(steps_m[v], cfg_m[v].freq));
            end
            mix_m = scaled_mix(sum, volume_m, via_cb2_i, diag_i);
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (!cfg_m[v].gate)
                    steps_m[v] = 0;      // gate low holds phase at 0
                else if (cpu_en_i)
                    steps_m[v]++;
            end
            if (cpu_en_i && sid_en_i && cpu_wr_en_i)
                apply_write(addr_i, data_i);  // config lands after this edge
        end
    end

endmodule

// ==== test/audio_tb.sv ====
// audio testbench
// clock, cpu enable, register writes and reads, density windows and watchdog

module audio_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import audio_pkg::*;

    localparam int        CLK_PERIOD   = 8;
    localparam int        WINDOW_CLKS  = 4096;  // density window length
    localparam int        NUM_TESTS    = 7;     // window sized test segments
    localparam int        MARGIN_CLKS  = 4096;
    localparam int        TIMEOUT_CLKS = NUM_TESTS * WINDOW_CLKS + MARGIN_CLKS;
    localparam int        OSC3_RUNS    = 8;
    localparam int        EXP_WINDOWS  = 6;     // reset closed windows
    localparam reg_addr_t V2_BASE      = reg_addr_t'(2 * VOICE_STRIDE);

    typedef struct packed {
        logic      sid_en;
        logic      wr_en;
        reg_addr_t addr;
        reg_data_t data;
    } cpu_bus_t;

    logic      clk_i = 1'b0;
    logic      reset_i;
    logic      cpu_en_i;
    logic      diag_i;
    logic      via_cb2_i;
    logic      audio_o;
    reg_data_t data_o;
    cpu_bus_t  bus;
    logic [2:0] en_cnt;
    int        seed;
    int        value_errs;
    int        other_errs;
    int        windows;
    int        tb_errs = 0;

    audio uut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cpu_en_i    (cpu_en_i),
        .sid_en_i    (bus.sid_en),
        .cpu_wr_en_i (bus.wr_en),
        .addr_i      (bus.addr),
        .data_i      (bus.data),
        .data_o      (data_o),
        .diag_i      (diag_i),
        .via_cb2_i   (via_cb2_i),
        .audio_o     (audio_o)
    );

    audio_checker chk (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cpu_en_i     (cpu_en_i),
        .sid_en_i     (bus.sid_en),
        .cpu_wr_en_i  (bus.wr_en),
        .addr_i       (bus.addr),
        .data_i       (bus.data),
        .rd_data_i    (data_o),
        .diag_i       (diag_i),
        .via_cb2_i    (via_cb2_i),
        .audio_i      (audio_o),
        .value_errs_o (value_errs),
        .other_errs_o (other_errs),
        .windows_o    (windows)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin : enable_gen
        en_cnt   = '0;
        cpu_en_i = 1'b0;
        forever begin
            @(negedge clk_i);
            en_cnt   = en_cnt + 3'd1;
            cpu_en_i = (en_cnt == 3'd7);  // one clock in eight
        end
    end

    task automatic wait_enables(int n);
        repeat (n) begin
            @(posedge clk_i);
            while (!cpu_en_i) @(posedge clk_i);
        end
    endtask

    // one chip select access held until an enable edge takes it
    task automatic bus_access(logic wr, reg_addr_t a, reg_data_t d);
        @(negedge clk_i);
        bus.sid_en = 1'b1;
        bus.wr_en  = wr;
        bus.addr   = a;
        bus.data   = d;
        wait_enables(1);
        @(negedge clk_i);
        bus.sid_en = 1'b0;
        bus.wr_en  = 1'b0;
    endtask

    task automatic write_reg(reg_addr_t a, reg_data_t d);
        bus_access(1'b1, a, d);
    endtask

    task automatic read_reg(reg_addr_t a);
        bus_access(1'b0, a, '0);
    endtask

    task automatic apply_reset();
        @(negedge clk_i);
        reset_i = 1'b1;
        repeat (3) @(negedge clk_i);
        reset_i = 1'b0;
    endtask

    task automatic run_window();
        repeat (WINDOW_CLKS) @(negedge clk_i);
    endtask

    initial begin : stimulus
        phase_t freq;
        int     waits;
        bus       = '0;
        reset_i   = 1'b1;
        diag_i    = 1'b0;
        via_cb2_i = 1'b0;
        seed      = 32'had2d_911b;
        repeat (3) @(negedge clk_i);
        reset_i = 1'b0;

        run_window();  // idle voices leave the mix at minus cb2 level
        apply_reset();

        for (int i = 0; i < OSC3_RUNS; i++) begin
            freq  = phase_t'($random(seed));
            waits = 1 + int'($random(seed) & 31);
            write_reg(V2_BASE + REG_CTRL, 8'h00);     // gate off clears phase
            write_reg(V2_BASE + REG_FREQ_LO, freq[7:0]);
            write_reg(V2_BASE + REG_FREQ_HI, freq[15:8]);
            write_reg(V2_BASE + REG_CTRL, 8'h21);     // saw with gate on
            wait_enables(waits);
            read_reg(REG_OSC3);
            write_reg(V2_BASE + REG_CTRL, 8'h00);
            read_reg(REG_OSC3);                       // gated off
        end

        // write only registers read back 0
        read_reg(REG_FREQ_LO);
        read_reg(REG_FREQ_HI);
        read_reg(REG_CTRL);
        read_reg(V2_BASE + REG_FREQ_LO);
        read_reg(V2_BASE + REG_CTRL);
        read_reg(REG_VOLUME);
        for (int i = 0; i < 8; i++) begin
            read_reg(reg_addr_t'($random(seed)));
        end
        apply_reset();

        via_cb2_i = 1'b1;
        diag_i    = 1'b1;  // jumper allows cb2 so level is added
        run_window();
        apply_reset();
        diag_i = 1'b0;     // level removed
        run_window();
        apply_reset();
        via_cb2_i = 1'b0;

        // all squares at freq 0 for full negative drive
        for (int v = 0; v < NUM_VOICES; v++) begin
            write_reg(reg_addr_t'(v * VOICE_STRIDE) + REG_CTRL, 8'h11);
        end
        write_reg(REG_VOLUME, 8'h0F);
        run_window();
        apply_reset();
        write_reg(REG_CTRL, 8'h20);  // saw only on voice 0 with gate still low
        write_reg(REG_CTRL, 8'h21);
        write_reg(REG_VOLUME, 8'h0F);
        run_window();
        apply_reset();

        if (windows != EXP_WINDOWS) begin
            tb_errs++;
            $display("only %0d of %0d density windows were checked", windows, EXP_WINDOWS);
        end
        $display("errors: value %0d, other %0d", value_errs, other_errs + tb_errs);
        if (value_errs == 0 && other_errs + tb_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CLKS * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d clocks", TIMEOUT_CLKS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== pet_audio.f ====
design/audio_pkg.sv
design/tone_regs.sv
design/tone_voice.sv
design/audio_mixer.sv
design/delta_sigma_dac.sv
design/audio.sv
test/audio_checker.sv
test/audio_tb.sv
